/* common/rv32i_types_pkg.sv */
package rv32i_types_pkg;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    // coarse class, same grouping as the ROB uses
    typedef enum logic [1:0] {
        alu  = 2'b00,
        br   = 2'b01,
        mem  = 2'b10,
        none = 2'b11
    } op_class_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // shared layout of I and S formats
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2_or_imm_lo;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo_or_rd;
        logic [6:0] opcode;
    } is_fmt_t;

    // one instruction word, two field views
    typedef union packed {
        r_fmt_t  r;
        is_fmt_t i;
    } instr_u;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] order;
        op_class_e   op_class;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        // sign extended, format dependent
        logic [31:0] imm;
        logic        uses_rd;
        logic        illegal;
    } decoded_instr_t;

endpackage

/* common/fetch_pkg.sv */
package fetch_pkg;

    // memory line geometry
    localparam int LINE_BITS      = 256;
    localparam int BEAT_BITS      = 64;
    localparam int BEATS_PER_LINE = 4;
    localparam int OFFSET_BITS    = 5;
    localparam int TAG_BITS       = 32 - OFFSET_BITS;

    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [BEAT_BITS-1:0] beat_t;

    // line address, pc bits 31 to 5
    typedef logic [TAG_BITS-1:0] tag_t;

    // position of a beat within its line
    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_idx_t;

    // one fetched word on its way to decode
    typedef struct packed {
        logic [31:0] order;
        logic [31:0] pc;
        logic [31:0] instr;
    } queue_entry_t;

endpackage

/* fetch/fetch_fsm.sv */
`timescale 1ns/1ns

module fetch_fsm #(
    parameter logic [31:0] RESET_PC = 32'haaaaa000
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    redirect_i,
    input  logic [31:0]             redirect_pc_i,
    input  logic                    hit_i,
    input  logic [31:0]             word_i,
    input  logic                    last_beat_i,
    input  logic                    bmem_ready_i,
    output logic [31:0]             bmem_addr_o,
    output logic                    bmem_read_o,
    output fetch_pkg::tag_t         fill_tag_o,
    output logic [31:0]             pc_o,
    output logic                    enq_valid_o,
    output fetch_pkg::queue_entry_t enq_entry_o,
    input  logic                    full_i
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {LOOKUP, REQUEST, FILL} state_e;

    state_e      state_q;
    logic [31:0] pc_q;
    logic [31:0] order_q;
    logic        req_q;
    tag_t        fill_tag_q;
    // redirect that arrived while a burst was open
    logic        redir_pend_q;
    logic [31:0] redir_pc_q;

    assign enq_valid_o = (state_q == LOOKUP) && hit_i && !full_i && !redirect_i;
    assign enq_entry_o = '{order: order_q, pc: pc_q, instr: word_i};

    assign pc_o        = pc_q;
    assign fill_tag_o  = fill_tag_q;
    assign bmem_read_o = req_q;
    assign bmem_addr_o = {fill_tag_q, {OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= LOOKUP;
            pc_q         <= RESET_PC;
            order_q      <= '0;
            req_q        <= 1'b0;
            redir_pend_q <= 1'b0;
        end else begin
            case (state_q)
                LOOKUP: begin
                    if (redirect_i) begin
                        pc_q <= redirect_pc_i;
                    end else if (!hit_i) begin
                        // on a miss latch the line address and ask memory
                        fill_tag_q <= pc_q[31:OFFSET_BITS];
                        req_q      <= 1'b1;
                        state_q    <= REQUEST;
                    end else if (enq_valid_o) begin
                        pc_q    <= pc_q + 32'd4;
                        order_q <= order_q + 32'd1;
                    end
                end
                REQUEST: begin
                    if (redirect_i) begin
                        redir_pend_q <= 1'b1;
                        redir_pc_q   <= redirect_pc_i;
                    end
                    if (bmem_ready_i) begin
                        req_q   <= 1'b0;
                        state_q <= FILL;
                    end
                end
                FILL: begin
                    if (last_beat_i) begin
                        state_q      <= LOOKUP;
                        redir_pend_q <= 1'b0;
                        if (redirect_i) begin
                            pc_q <= redirect_pc_i;
                        end else if (redir_pend_q) begin
                            pc_q <= redir_pc_q;
                        end
                    end else if (redirect_i) begin
                        redir_pend_q <= 1'b1;
                        redir_pc_q   <= redirect_pc_i;
                    end
                end
                default: state_q <= LOOKUP;
            endcase
        end
    end

    a_read_in_request: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |-> state_q == REQUEST)
        else $error("bmem_read_o high outside REQUEST");

    // a hit can only come from the line fetched last
    a_no_enq_on_miss: assert property (@(posedge clk) disable iff (rst)
        enq_valid_o |-> pc_q[31:OFFSET_BITS] == fill_tag_q)
        else $error("enqueue during a miss");

endmodule

/* fetch/burst_counter.sv */
`timescale 1ns/1ns

module burst_counter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rvalid_i,
    output fetch_pkg::beat_idx_t beat_idx_o,
    output logic                 last_beat_o
);
    import fetch_pkg::*;

    beat_idx_t count_q;

    // wraps back to zero after the fourth beat
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (rvalid_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign beat_idx_o  = count_q;
    assign last_beat_o = rvalid_i && (count_q == beat_idx_t'(BEATS_PER_LINE - 1));

endmodule

/* fetch/line_buffer.sv */
`timescale 1ns/1ns

module line_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [31:0]          pc_i,
    input  fetch_pkg::tag_t      fill_tag_i,
    input  fetch_pkg::beat_t     beat_i,
    input  logic                 beat_valid_i,
    input  fetch_pkg::beat_idx_t beat_idx_i,
    input  logic                 last_beat_i,
    output logic                 hit_o,
    output logic [31:0]          word_o
);
    import fetch_pkg::*;

    line_t line_q;
    tag_t  tag_q;
    logic  valid_q;

    always_ff @(posedge clk) begin
        if (beat_valid_i) begin
            line_q[{beat_idx_i, 6'd0} +: BEAT_BITS] <= beat_i;
        end
        if (last_beat_i) begin
            tag_q <= fill_tag_i;
        end
    end

    // invalid from the first beat until the whole line is in
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (last_beat_i) begin
            valid_q <= 1'b1;
        end else if (beat_valid_i && beat_idx_i == '0) begin
            valid_q <= 1'b0;
        end
    end

    assign hit_o  = valid_q && (pc_i[31:OFFSET_BITS] == tag_q);
    assign word_o = line_q[{pc_i[4:2], 5'd0} +: 32];

    // later beats only arrive inside a fill that beat 0 opened
    a_beat_order: assert property (@(posedge clk) disable iff (rst)
        (beat_valid_i && beat_idx_i != '0) |-> !valid_q)
        else $error("beat out of order outside a fill");

endmodule

/* hdl/instr_queue.sv */
`timescale 1ns/1ns

module instr_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush_i,
    input  logic                    enq_i,
    input  fetch_pkg::queue_entry_t entry_i,
    output logic                    full_o,
    output logic                    valid_o,
    output fetch_pkg::queue_entry_t entry_o,
    input  logic                    deq_i
);
    import fetch_pkg::*;

    localparam int PTR_BITS = $clog2(QUEUE_DEPTH);

    queue_entry_t          entries_q [QUEUE_DEPTH];
    logic [PTR_BITS-1:0]   wr_ptr_q;
    logic [PTR_BITS-1:0]   rd_ptr_q;
    logic [PTR_BITS:0]     count_q;

    // a full queue still takes an entry while the head leaves
    assign full_o  = (count_q == (PTR_BITS+1)'(QUEUE_DEPTH)) && !deq_i;
    assign valid_o = (count_q != '0);
    assign entry_o = entries_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (enq_i && !flush_i) begin
            entries_q[wr_ptr_q] <= entry_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (enq_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (deq_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({enq_i, deq_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    a_no_enq_full: assert property (@(posedge clk) disable iff (rst)
        enq_i |-> !full_o)
        else $error("enqueue while full");

    a_no_deq_empty: assert property (@(posedge clk) disable iff (rst)
        deq_i |-> valid_o)
        else $error("dequeue while empty");

endmodule

/* hdl/decode_unit.sv */
`timescale 1ns/1ns

module decode_unit (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            flush_i,
    input  logic                            in_valid_i,
    input  fetch_pkg::queue_entry_t         entry_i,
    output logic                            in_ready_o,
    output logic                            out_valid_o,
    output rv32i_types_pkg::decoded_instr_t out_o,
    input  logic                            out_ready_i
);
    import rv32i_types_pkg::*;

    instr_u         instr_union;
    decoded_instr_t dec_d;
    decoded_instr_t out_q;
    logic           valid_q;

    assign instr_union = entry_i.instr;

    always_comb begin
        dec_d.pc       = entry_i.pc;
        dec_d.order    = entry_i.order;
        dec_d.rd       = instr_union.r.rd;
        dec_d.rs1      = instr_union.r.rs1;
        dec_d.rs2      = instr_union.r.rs2;
        dec_d.funct3   = instr_union.r.funct3;
        dec_d.op_class = none;
        dec_d.imm      = '0;
        dec_d.uses_rd  = 1'b1;
        dec_d.illegal  = 1'b0;
        case (instr_union.r.opcode)
            op_lui, op_auipc: begin
                dec_d.op_class = alu;
                dec_d.imm = {instr_union.r.funct7, instr_union.r.rs2, instr_union.r.rs1,
                             instr_union.r.funct3, 12'h000};
            end
            op_jal: begin
                dec_d.op_class = br;
                // J immediate is scattered over the r view fields
                dec_d.imm = {{11{instr_union.r.funct7[6]}}, instr_union.r.funct7[6],
                             instr_union.r.rs1, instr_union.r.funct3, instr_union.r.rs2[0],
                             instr_union.r.funct7[5:0], instr_union.r.rs2[4:1], 1'b0};
            end
            op_jalr, op_load, op_imm: begin
                dec_d.op_class = (instr_union.r.opcode == op_jalr) ? br :
                                 (instr_union.r.opcode == op_load) ? mem : alu;
                dec_d.imm = {{20{instr_union.i.imm_hi[6]}}, instr_union.i.imm_hi,
                             instr_union.i.rs2_or_imm_lo};
            end
            op_br: begin
                dec_d.op_class = br;
                dec_d.uses_rd  = 1'b0;
                dec_d.imm = {{19{instr_union.i.imm_hi[6]}}, instr_union.i.imm_hi[6],
                             instr_union.i.imm_lo_or_rd[0], instr_union.i.imm_hi[5:0],
                             instr_union.i.imm_lo_or_rd[4:1], 1'b0};
            end
            op_store: begin
                dec_d.op_class = mem;
                dec_d.uses_rd  = 1'b0;
                dec_d.imm = {{20{instr_union.i.imm_hi[6]}}, instr_union.i.imm_hi,
                             instr_union.i.imm_lo_or_rd};
            end
            op_reg: begin
                dec_d.op_class = alu;
            end
            default: begin
                dec_d.illegal = 1'b1;
                dec_d.uses_rd = 1'b0;
            end
        endcase
    end

    // load enable, stage empty or draining this cycle
    assign in_ready_o = in_valid_i && (!valid_q || out_ready_i);

    always_ff @(posedge clk) begin
        if (in_ready_o && !flush_i) begin
            out_q <= dec_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    assign out_valid_o = valid_q;
    assign out_o       = out_q;

endmodule

/* hdl/fetch_frontend.sv */
`timescale 1ns/1ns

module fetch_frontend #(
    parameter logic [31:0] RESET_PC    = 32'haaaaa000,
    parameter int          QUEUE_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            rst,

    output logic [31:0]                     bmem_addr_o,
    output logic                            bmem_read_o,
    input  logic                            bmem_ready_i,
    input  fetch_pkg::beat_t                bmem_rdata_i,
    input  logic                            bmem_rvalid_i,

    input  logic                            redirect_i,
    input  logic [31:0]                     redirect_pc_i,

    output logic                            dec_valid_o,
    output rv32i_types_pkg::decoded_instr_t dec_o,
    input  logic                            dec_ready_i
);
    import fetch_pkg::*;

    logic         hit;
    logic [31:0]  word;
    logic [31:0]  pc;
    tag_t         fill_tag;
    beat_idx_t    beat_idx;
    logic         last_beat;

    logic         enq_valid;
    queue_entry_t enq_entry;
    logic         full;
    logic         head_valid;
    queue_entry_t head_entry;
    logic         deq;

    fetch_fsm #(
        .RESET_PC      (RESET_PC)
    ) u_fetch_fsm (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .hit_i         (hit),
        .word_i        (word),
        .last_beat_i   (last_beat),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .fill_tag_o    (fill_tag),
        .pc_o          (pc),
        .enq_valid_o   (enq_valid),
        .enq_entry_o   (enq_entry),
        .full_i        (full)
    );

    burst_counter u_burst_counter (
        .clk           (clk),
        .rst           (rst),
        .rvalid_i      (bmem_rvalid_i),
        .beat_idx_o    (beat_idx),
        .last_beat_o   (last_beat)
    );

    line_buffer u_line_buffer (
        .clk           (clk),
        .rst           (rst),
        .pc_i          (pc),
        .fill_tag_i    (fill_tag),
        .beat_i        (bmem_rdata_i),
        .beat_valid_i  (bmem_rvalid_i),
        .beat_idx_i    (beat_idx),
        .last_beat_i   (last_beat),
        .hit_o         (hit),
        .word_o        (word)
    );

    // redirect empties the queue and the decode stage together
    instr_queue #(
        .QUEUE_DEPTH   (QUEUE_DEPTH)
    ) u_instr_queue (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (redirect_i),
        .enq_i         (enq_valid),
        .entry_i       (enq_entry),
        .full_o        (full),
        .valid_o       (head_valid),
        .entry_o       (head_entry),
        .deq_i         (deq)
    );

    decode_unit u_decode_unit (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (redirect_i),
        .in_valid_i    (head_valid),
        .entry_i       (head_entry),
        .in_ready_o    (deq),
        .out_valid_o   (dec_valid_o),
        .out_o         (dec_o),
        .out_ready_i   (dec_ready_i)
    );

endmodule

/* bench/bench_mem.sv */
`timescale 1ns/1ns

module bench_mem #(
    parameter logic [31:0] BASE = 32'haaaaa000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [31:0]      addr_i,
    input  logic             read_i,
    output logic             ready_o,
    output fetch_pkg::beat_t rdata_o,
    output logic             rvalid_o,
    output int               req_count_o,
    output logic [31:0]      first_addr_o
);
    import fetch_pkg::*;

    localparam int PROG_WORDS = 24;

    logic [31:0] prog [PROG_WORDS];
    logic [31:0] lfsr;
    logic [31:0] pend_addr;
    logic [31:0] line_addr;
    logic        busy;
    int          beat;

    initial begin
        prog = '{32'h123450b7, 32'h00001117, 32'hfff08193, 32'h00208233,
                 32'h00812283, 32'hfe512e23, 32'hfe208ce3, 32'h010000ef,
                 32'h00008067, 32'hffffffff, 32'h40320333, 32'h0000c383,
                 32'h00000013, 32'h80000537, 32'h00150513, 32'h00a5a023,
                 32'hfe0518e3, 32'h00c0006f, 32'h00100093, 32'h00208663,
                 32'h000280e7, 32'h00c12083, 32'h40000017, 32'h0040006f};
        lfsr     = 32'he5c3_fb47;
        ready_o  = 1'b0;
        rvalid_o = 1'b0;
        rdata_o  = '0;
    end

    // galois form stepped once per random bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    // words outside the program read as NOP
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        if (addr >= BASE && addr < BASE + 4 * PROG_WORDS) begin
            return prog[(addr - BASE) >> 2];
        end
        return 32'h00000013;
    endfunction

    always @(negedge clk) begin
        if (rst) begin
            ready_o      = 1'b0;
            rvalid_o     = 1'b0;
            rdata_o      = '0;
            busy         = 1'b0;
            beat         = 0;
            req_count_o  = 0;
            first_addr_o = '0;
        end else begin
            // a beat shown last half cycle was taken at the rising edge
            if (rvalid_o) begin
                beat = beat + 1;
                if (beat == BEATS_PER_LINE) begin
                    busy = 1'b0;
                end
            end
            rvalid_o = 1'b0;
            if (ready_o) begin
                busy      = 1'b1;
                beat      = 0;
                line_addr = pend_addr;
                if (req_count_o == 0) begin
                    first_addr_o = pend_addr;
                end
                req_count_o = req_count_o + 1;
                ready_o     = 1'b0;
            end
            if (busy) begin
                lfsr = lfsr_next(lfsr);
                if (lfsr[0]) begin
                    rvalid_o = 1'b1;
                    rdata_o  = {word_at(line_addr + 8 * beat + 4), word_at(line_addr + 8 * beat)};
                end
            end else if (read_i) begin
                lfsr      = lfsr_next(lfsr);
                ready_o   = lfsr[0];
                pend_addr = addr_i;
            end
        end
    end

endmodule

/* bench/fetch_frontend_tb.sv */
`timescale 1ns/1ns

module fetch_frontend_tb;
    import rv32i_types_pkg::*;
    import fetch_pkg::*;

    localparam logic [31:0] BASE     = 32'haaaaa000;
    localparam int          NUM_ROWS = 20;
    // no redirect, redirect once the queue is full, redirect during a burst
    localparam logic [1:0]  RD_NONE  = 2'd0;
    localparam logic [1:0]  RD_FULL  = 2'd1;
    localparam logic [1:0]  RD_BURST = 2'd2;

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] target;
        logic [7:0]  stall;
        logic [31:0] pc;
        logic [31:0] order;
        logic [31:0] word;
    } row_t;

    logic           clk;
    logic           rst;
    logic [31:0]    bmem_addr;
    logic           bmem_read;
    logic           bmem_ready;
    beat_t          bmem_rdata;
    logic           bmem_rvalid;
    logic           redirect_i;
    logic [31:0]    redirect_pc_i;
    logic           dec_valid_o;
    decoded_instr_t dec_o;
    logic           dec_ready_i;
    int             req_count;
    logic [31:0]    first_addr;

    row_t           rows[$];
    logic [31:0]    lfsr;

    fetch_frontend #(
        .RESET_PC    (BASE),
        .QUEUE_DEPTH (8)
    ) UUT (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .dec_valid_o   (dec_valid_o),
        .dec_o         (dec_o),
        .dec_ready_i   (dec_ready_i)
    );

    bench_mem #(
        .BASE (BASE)
    ) u_mem (
        .clk          (clk),
        .rst          (rst),
        .addr_i       (bmem_addr),
        .read_i       (bmem_read),
        .ready_o      (bmem_ready),
        .rdata_o      (bmem_rdata),
        .rvalid_o     (bmem_rvalid),
        .req_count_o  (req_count),
        .first_addr_o (first_addr)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    initial begin
        #((NUM_ROWS * 64 + 8) * 10);
        $display("run did not finish in time, no record arrived");
        $display("Testbench failed");
        $fatal(1);
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    // expected record from the RV32I field layout
    function automatic decoded_instr_t expect_decoded(input logic [31:0] pc,
                                                      input logic [31:0] order,
                                                      input logic [31:0] w);
        decoded_instr_t d;
        d.pc       = pc;
        d.order    = order;
        d.rd       = w[11:7];
        d.rs1      = w[19:15];
        d.rs2      = w[24:20];
        d.funct3   = w[14:12];
        d.imm      = '0;
        d.uses_rd  = 1'b1;
        d.illegal  = 1'b0;
        d.op_class = none;
        case (w[6:0])
            op_lui, op_auipc: begin
                d.op_class = alu;
                d.imm      = {w[31:12], 12'h000};
            end
            op_jal: begin
                d.op_class = br;
                d.imm      = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            op_jalr, op_load, op_imm: begin
                d.op_class = (w[6:0] == op_jalr) ? br : (w[6:0] == op_load) ? mem : alu;
                d.imm      = {{20{w[31]}}, w[31:20]};
            end
            op_br: begin
                d.op_class = br;
                d.uses_rd  = 1'b0;
                d.imm      = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            op_store: begin
                d.op_class = mem;
                d.uses_rd  = 1'b0;
                d.imm      = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            op_reg: d.op_class = alu;
            default: begin
                d.illegal = 1'b1;
                d.uses_rd = 1'b0;
            end
        endcase
        return d;
    endfunction

    task automatic check_decoded(input string name, input decoded_instr_t exp,
                                 input decoded_instr_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic add_row(input logic [1:0] kind, input logic [31:0] target, input int stall,
                           input int offs, input int order, input logic [31:0] word);
        rows.push_back('{kind, target, stall[7:0], BASE + offs, order, word});
    endtask

    // ready goes high after the stall and the record is taken at the next rising edge
    task automatic get_record(input int stall, output decoded_instr_t rec);
        int  n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            dec_ready_i = (n >= stall);
            if (dec_ready_i && dec_valid_o) begin
                rec  = dec_o;
                done = 1'b1;
            end
            n++;
        end
    endtask

    task automatic send_redirect(input logic [31:0] target);
        redirect_i    = 1'b1;
        redirect_pc_i = target;
        @(negedge clk);
        redirect_i    = 1'b0;
    endtask

    task automatic wait_for_request();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            dec_ready_i = 1'b0;
            n++;
            if (n > 200) begin
                $display("no memory request seen before the redirect");
                $display("Testbench failed");
                $fatal(1);
            end
        end while (!bmem_read);
    endtask

    initial begin
        decoded_instr_t rec;
        int             stall;
        rst           = 1'b1;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        dec_ready_i   = 1'b0;
        lfsr          = 32'he5c3_fb47;

        // 255 in the stall column draws a random low period
        add_row(RD_NONE,  0,           0,   'h00, 0,  32'h123450b7);
        add_row(RD_NONE,  0,           0,   'h04, 1,  32'h00001117);
        add_row(RD_NONE,  0,           12,  'h08, 2,  32'hfff08193);
        add_row(RD_NONE,  0,           0,   'h0c, 3,  32'h00208233);
        add_row(RD_NONE,  0,           255, 'h10, 4,  32'h00812283);
        add_row(RD_NONE,  0,           0,   'h14, 5,  32'hfe512e23);
        add_row(RD_NONE,  0,           0,   'h18, 6,  32'hfe208ce3);
        add_row(RD_NONE,  0,           255, 'h1c, 7,  32'h010000ef);
        add_row(RD_NONE,  0,           3,   'h20, 8,  32'h00008067);
        add_row(RD_NONE,  0,           0,   'h24, 9,  32'hffffffff);
        add_row(RD_NONE,  0,           255, 'h28, 10, 32'h40320333);
        add_row(RD_NONE,  0,           0,   'h2c, 11, 32'h0000c383);
        add_row(RD_NONE,  0,           12,  'h30, 12, 32'h00000013);
        add_row(RD_NONE,  0,           0,   'h34, 13, 32'h80000537);
        // decode holds order 14 and the queue 15 to 22, so the count stands at 23
        add_row(RD_FULL,  BASE + 'h44, 0,   'h44, 23, 32'h00c0006f);
        add_row(RD_NONE,  0,           0,   'h48, 24, 32'h00100093);
        // miss at offset 0x60 leaves the count at 30
        add_row(RD_BURST, BASE + 'h08, 0,   'h08, 30, 32'hfff08193);
        add_row(RD_NONE,  0,           255, 'h0c, 31, 32'h00208233);
        add_row(RD_NONE,  0,           0,   'h10, 32, 32'h00812283);
        add_row(RD_NONE,  0,           2,   'h14, 33, 32'hfe512e23);

        repeat (8) @(negedge clk);
        rst = 1'b0;
        check_flag("dec_valid after reset", 1'b0, dec_valid_o);

        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].kind == RD_FULL) begin
                repeat (60) begin
                    @(negedge clk);
                    dec_ready_i = 1'b0;
                end
                check_count("line requests before redirect", 3, req_count);
                send_redirect(rows[i].target);
            end else if (rows[i].kind == RD_BURST) begin
                wait_for_request();
                send_redirect(rows[i].target);
            end
            stall = (rows[i].stall == 8'd255) ? random_bits(5) : int'(rows[i].stall);
            get_record(stall, rec);
            check_decoded($sformatf("row %0d", i),
                          expect_decoded(rows[i].pc, rows[i].order, rows[i].word), rec);
        end

        check_addr("first request address", BASE & 32'hffff_ffe0, first_addr);

        $display("Testbench passed");
        $finish;
    end

endmodule

/* fetch_frontend.f */
common/rv32i_types_pkg.sv
common/fetch_pkg.sv
fetch/fetch_fsm.sv
fetch/burst_counter.sv
fetch/line_buffer.sv
hdl/instr_queue.sv
hdl/decode_unit.sv
hdl/fetch_frontend.sv
bench/bench_mem.sv
bench/fetch_frontend_tb.sv
